//--- fetch_unit.f
design/fetch_pkg.sv
design/thread_select_fsm.sv
design/slice_timer.sv
design/thread_pc.sv
design/fetch_bundle.sv
design/fetch_unit.sv
bench/fetch_unit_sva.sv
bench/fetch_unit_tb.sv

//--- bench/fetch_unit_tb.sv
// random traffic for a fixed cycle count; memory answers every cycle with a pattern of the address
`timescale 1ns/1ps

module fetch_unit_tb;

	import fetch_pkg::*;

	localparam int clock_period = 4;
	localparam int reset_cycles = 10;
	localparam int num_cycles   = 4000;
	localparam int mode_cycles  = 200;   // is_two_threads flips this often

	logic                  clock;
	logic                  reset;
	logic                  is_two_threads;
	logic [word_width-1:0] imem2proc_data;
	logic                  imem2proc_valid;
	logic                  rs_stall;
	logic                  rat_stall;
	logic                  rob1_stall;
	logic                  rob2_stall;
	logic                  thread1_structure_hazard_stall;
	logic                  thread2_structure_hazard_stall;
	logic                  thread1_branch_taken;
	logic                  thread2_branch_taken;
	logic [addr_width-1:0] thread1_target_pc;
	logic [addr_width-1:0] thread2_target_pc;
	logic [addr_width-1:0] proc2imem_addr;
	logic [inst_width-1:0] inst1_out;
	logic [inst_width-1:0] inst2_out;
	logic                  inst1_valid;
	logic                  inst2_valid;
	logic                  inst_thread;
	logic [addr_width-1:0] next_pc_out;
	logic                  thread1_active;

	integer seed;

	// reference model state
	thread_state           m_state;
	int                    m_count;   // cycles left in the slice, minus one
	logic [addr_width-1:0] m_pc1;
	logic [addr_width-1:0] m_pc2;
	logic [inst_width-1:0] exp_inst1;
	logic [inst_width-1:0] exp_inst2;
	logic                  exp_valid1;
	logic                  exp_valid2;
	logic                  exp_thread;
	logic [addr_width-1:0] exp_next_pc;
	int                    fires1;
	int                    fires2;
	int                    redirects;

	fetch_unit fetch_unit_i
	(
		.clock                          (clock),
		.reset                          (reset),
		.is_two_threads                 (is_two_threads),
		.imem2proc_data                 (imem2proc_data),
		.imem2proc_valid                (imem2proc_valid),
		.rs_stall                       (rs_stall),
		.rat_stall                      (rat_stall),
		.rob1_stall                     (rob1_stall),
		.rob2_stall                     (rob2_stall),
		.thread1_structure_hazard_stall (thread1_structure_hazard_stall),
		.thread2_structure_hazard_stall (thread2_structure_hazard_stall),
		.thread1_branch_taken           (thread1_branch_taken),
		.thread2_branch_taken           (thread2_branch_taken),
		.thread1_target_pc              (thread1_target_pc),
		.thread2_target_pc              (thread2_target_pc),
		.proc2imem_addr                 (proc2imem_addr),
		.inst1_out                      (inst1_out),
		.inst2_out                      (inst2_out),
		.inst1_valid                    (inst1_valid),
		.inst2_valid                    (inst2_valid),
		.inst_thread                    (inst_thread),
		.next_pc_out                    (next_pc_out),
		.thread1_active                 (thread1_active)
	);

	bind fetch_unit fetch_unit_sva fetch_unit_sva_i
	(
		.clock          (clock),
		.reset          (reset),
		.inst1_valid    (inst1_valid),
		.inst2_valid    (inst2_valid),
		.proc2imem_addr (proc2imem_addr)
	);

	always #(clock_period / 2) clock = ~clock;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// upper word holds the folded address, lower word its inverse
	function automatic logic [word_width-1:0] mem_word(input logic [addr_width-1:0] addr);
		logic [inst_width-1:0] fold;
		fold = addr[addr_width-1:inst_width] ^ addr[inst_width-1:0];
		return {fold, ~fold};
	endfunction

	function automatic logic [addr_width-1:0] aligned(input logic [addr_width-1:0] pc);
		return {pc[addr_width-1:3], 3'b000};
	endfunction

	// mid-word entry takes one instruction, a full word takes two
	function automatic logic [addr_width-1:0] step_pc(input logic [addr_width-1:0] pc);
		return pc[2] ? pc + 64'd4 : pc + 64'd8;
	endfunction

	function automatic logic chance(input int percent);
		return ((($random(seed)) & 32'h7fff_ffff) % 100) < percent;
	endfunction

	function automatic logic [addr_width-1:0] random_target();
		logic [addr_width-1:0] target;
		target = {$random(seed), $random(seed)};
		return {target[addr_width-1:2], 2'b00};   // instruction aligned
	endfunction

	task automatic stop_with_failure();
		$display("TEST FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [addr_width-1:0] got,
		input logic [addr_width-1:0] expected);
		assert (got === expected)
		else
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			stop_with_failure();
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	task automatic reset_model();
		m_state     = program_start;
		m_count     = slice_cycles - 1;
		m_pc1       = thread1_reset_pc;
		m_pc2       = thread2_reset_pc;
		exp_inst1   = '0;
		exp_inst2   = '0;
		exp_valid1  = 1'b0;
		exp_valid2  = 1'b0;
		exp_thread  = 1'b0;
		exp_next_pc = '0;
	endtask

	// one clock edge with the inputs now on the pins
	task automatic step_model();
		thread_state           next_state;
		logic                  done;
		logic                  fire1;
		logic                  fire2;
		logic [addr_width-1:0] fire_pc;
		logic [word_width-1:0] word;
		done = (m_count == 0);
		case (m_state)
			program_start: next_state = thread1_is_ex;
			thread1_is_ex: next_state = (is_two_threads && done) ? thread2_is_ex : thread1_is_ex;
			default:       next_state = (!is_two_threads || done) ? thread1_is_ex : thread2_is_ex;
		endcase
		fire1 = (m_state == thread1_is_ex) && imem2proc_valid && !thread1_branch_taken
			&& !(rs_stall || rat_stall || rob1_stall || thread1_structure_hazard_stall);
		fire2 = (m_state == thread2_is_ex) && imem2proc_valid && !thread2_branch_taken
			&& !(rs_stall || rat_stall || rob2_stall || thread2_structure_hazard_stall);
		fire_pc = fire2 ? m_pc2 : m_pc1;
		word    = mem_word(aligned(fire_pc));

		exp_valid1  = fire1 || fire2;
		exp_valid2  = exp_valid1 && !fire_pc[2];
		exp_inst1   = !exp_valid1 ? '0 : (fire_pc[2] ? word[63:32] : word[31:0]);
		exp_inst2   = exp_valid2 ? word[63:32] : '0;
		exp_thread  = fire2;
		exp_next_pc = exp_valid1 ? step_pc(fire_pc) : '0;
		fires1      = fires1 + int'(fire1);
		fires2      = fires2 + int'(fire2);
		redirects   = redirects + int'(thread1_branch_taken) + int'(thread2_branch_taken);

		if (thread1_branch_taken)
			m_pc1 = thread1_target_pc;   // redirect beats a fetch
		else if (fire1)
			m_pc1 = step_pc(m_pc1);
		if (thread2_branch_taken)
			m_pc2 = thread2_target_pc;
		else if (fire2)
			m_pc2 = step_pc(m_pc2);

		m_count = (next_state != m_state || done) ? slice_cycles - 1 : m_count - 1;
		m_state = next_state;
	endtask

	//////////////////////////////////////////////////
	// stimulus and checks
	//////////////////////////////////////////////////

	task automatic check_outputs();
		check_value("proc2imem_addr", proc2imem_addr,
			aligned((m_state == thread2_is_ex) ? m_pc2 : m_pc1));
		check_value("thread1_active", thread1_active, m_state == thread1_is_ex);
		check_value("inst1_valid", inst1_valid, exp_valid1);
		check_value("inst2_valid", inst2_valid, exp_valid2);
		check_value("inst1_out", inst1_out, exp_inst1);
		check_value("inst2_out", inst2_out, exp_inst2);
		check_value("inst_thread", inst_thread, exp_thread);
		check_value("next_pc_out", next_pc_out, exp_next_pc);
	endtask

	task automatic drive_inputs(input int cycle);
		imem2proc_data                 = mem_word(proc2imem_addr);   // answer the current address
		imem2proc_valid                = chance(75);
		rs_stall                       = chance(10);
		rat_stall                      = chance(10);
		rob1_stall                     = chance(10);
		rob2_stall                     = chance(10);
		thread1_structure_hazard_stall = chance(10);
		thread2_structure_hazard_stall = chance(10);
		thread1_branch_taken           = chance(3);
		thread2_branch_taken           = chance(3);
		thread1_target_pc              = random_target();
		thread2_target_pc              = random_target();
		if (cycle % mode_cycles == mode_cycles - 1)
			is_two_threads = ~is_two_threads;
	endtask

	initial
	begin
		int cycle;
		seed                           = 32'h4d37;
		clock                          = 1'b0;
		reset                          = 1'b1;
		is_two_threads                 = 1'b1;
		imem2proc_data                 = '0;
		imem2proc_valid                = 1'b0;
		rs_stall                       = 1'b0;
		rat_stall                      = 1'b0;
		rob1_stall                     = 1'b0;
		rob2_stall                     = 1'b0;
		thread1_structure_hazard_stall = 1'b0;
		thread2_structure_hazard_stall = 1'b0;
		thread1_branch_taken           = 1'b0;
		thread2_branch_taken           = 1'b0;
		thread1_target_pc              = '0;
		thread2_target_pc              = '0;
		fires1                         = 0;
		fires2                         = 0;
		redirects                      = 0;
		reset_model();

		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (cycle = 0; cycle < num_cycles; cycle++)
		begin
			check_outputs();   // results of the last edge
			drive_inputs(cycle);
			step_model();
			@(negedge clock);
		end
		check_outputs();

		if (fires1 > 0 && fires2 > 0 && redirects > 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("error: traffic too thin, thread 1 fetched %0d, thread 2 fetched %0d, %0d redirects",
				fires1, fires2, redirects);
			stop_with_failure();
		end
	end

	// watchdog
	initial
	begin
		#((reset_cycles + num_cycles + 20) * clock_period);
		$display("error: run timed out at %0t ns before all cycles were checked", $time);
		stop_with_failure();
	end

endmodule

//--- bench/fetch_unit_sva.sv
// bound to fetch_unit; properties other than the reset check are off while reset is high
`timescale 1ns/1ps

module fetch_unit_sva
(
	input logic                             clock,
	input logic                             reset,
	input logic                             inst1_valid,
	input logic                             inst2_valid,
	input logic [fetch_pkg::addr_width-1:0] proc2imem_addr
);

	import fetch_pkg::*;

	//////////////////////////////////////////////////
	// output slots
	//////////////////////////////////////////////////

	// slot 2 never carries an instruction without slot 1
	slot2_needs_slot1: assert property (@(posedge clock) disable iff (reset)
		inst2_valid |-> inst1_valid)
	else
		$error("inst2_valid high while inst1_valid is low");

	// the start-state cycle right after reset fetches nothing
	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |=> !inst1_valid)
	else
		$error("inst1_valid high in the cycle after reset");

	//////////////////////////////////////////////////
	// memory address
	//////////////////////////////////////////////////

	word_aligned_addr: assert property (@(posedge clock) disable iff (reset)
		proc2imem_addr[2:0] == 3'b000)
	else
		$error("proc2imem_addr not aligned to a memory word");

endmodule

//--- design/fetch_unit.sv
// memory valid and all stalls are plain levels sampled each cycle; there is no request handshake
`timescale 1ns/1ps

module fetch_unit
(
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             is_two_threads,
	input  logic [fetch_pkg::word_width-1:0] imem2proc_data,
	input  logic                             imem2proc_valid,
	input  logic                             rs_stall,
	input  logic                             rat_stall,
	input  logic                             rob1_stall,
	input  logic                             rob2_stall,
	input  logic                             thread1_structure_hazard_stall,
	input  logic                             thread2_structure_hazard_stall,
	input  logic                             thread1_branch_taken,
	input  logic                             thread2_branch_taken,
	input  logic [fetch_pkg::addr_width-1:0] thread1_target_pc,
	input  logic [fetch_pkg::addr_width-1:0] thread2_target_pc,
	output logic [fetch_pkg::addr_width-1:0] proc2imem_addr,
	output logic [fetch_pkg::inst_width-1:0] inst1_out,
	output logic [fetch_pkg::inst_width-1:0] inst2_out,
	output logic                             inst1_valid,
	output logic                             inst2_valid,
	output logic                             inst_thread,
	output logic [fetch_pkg::addr_width-1:0] next_pc_out,
	output logic                             thread1_active
);

	import fetch_pkg::*;

	thread_state           owner_state;
	logic                  pc_enable1;
	logic                  pc_enable2;
	logic                  slice_restart;
	logic                  slice_done;
	logic [addr_width-1:0] pc1;
	logic [addr_width-1:0] pc2;
	logic [addr_width-1:0] advance_pc1;
	logic [addr_width-1:0] advance_pc2;
	logic                  fire1;
	logic                  fire2;

	//////////////////////////////////////////////////
	// port ownership
	//////////////////////////////////////////////////

	thread_select_fsm thread_select_fsm_i
	(
		.clock          (clock),
		.reset          (reset),
		.is_two_threads (is_two_threads),
		.slice_done     (slice_done),
		.owner_state    (owner_state),
		.pc_enable1     (pc_enable1),
		.pc_enable2     (pc_enable2),
		.slice_restart  (slice_restart),
		.thread1_active (thread1_active)
	);

	slice_timer slice_timer_i
	(
		.clock      (clock),
		.reset      (reset),
		.restart    (slice_restart),
		.slice_done (slice_done)
	);

	//////////////////////////////////////////////////
	// program counters
	//////////////////////////////////////////////////

	thread_pc thread_pc1_i
	(
		.clock                  (clock),
		.reset                  (reset),
		.reset_pc               (thread1_reset_pc),
		.pc_enable              (pc_enable1),
		.imem2proc_valid        (imem2proc_valid),
		.rs_stall               (rs_stall),   // shared with thread 2
		.rat_stall              (rat_stall),
		.rob_stall              (rob1_stall),
		.structure_hazard_stall (thread1_structure_hazard_stall),
		.branch_taken           (thread1_branch_taken),
		.target_pc              (thread1_target_pc),
		.pc                     (pc1),
		.advance_pc             (advance_pc1),
		.fire                   (fire1)
	);

	thread_pc thread_pc2_i
	(
		.clock                  (clock),
		.reset                  (reset),
		.reset_pc               (thread2_reset_pc),
		.pc_enable              (pc_enable2),
		.imem2proc_valid        (imem2proc_valid),
		.rs_stall               (rs_stall),
		.rat_stall              (rat_stall),
		.rob_stall              (rob2_stall),
		.structure_hazard_stall (thread2_structure_hazard_stall),
		.branch_taken           (thread2_branch_taken),
		.target_pc              (thread2_target_pc),
		.pc                     (pc2),
		.advance_pc             (advance_pc2),
		.fire                   (fire2)
	);

	//////////////////////////////////////////////////
	// address and fetch output
	//////////////////////////////////////////////////

	fetch_bundle fetch_bundle_i
	(
		.clock          (clock),
		.reset          (reset),
		.owner_state    (owner_state),
		.pc1            (pc1),
		.pc2            (pc2),
		.advance_pc1    (advance_pc1),
		.advance_pc2    (advance_pc2),
		.fire1          (fire1),
		.fire2          (fire2),
		.imem2proc_data (imem2proc_data),
		.proc2imem_addr (proc2imem_addr),
		.inst1_out      (inst1_out),
		.inst2_out      (inst2_out),
		.inst1_valid    (inst1_valid),
		.inst2_valid    (inst2_valid),
		.inst_thread    (inst_thread),
		.next_pc_out    (next_pc_out)
	);

endmodule

//--- design/fetch_bundle.sv
// the two fire inputs are never high together; outputs read as zero in cycles without a fetch
`timescale 1ns/1ps

module fetch_bundle
(
	input  logic                             clock,
	input  logic                             reset,
	input  fetch_pkg::thread_state           owner_state,
	input  logic [fetch_pkg::addr_width-1:0] pc1,
	input  logic [fetch_pkg::addr_width-1:0] pc2,
	input  logic [fetch_pkg::addr_width-1:0] advance_pc1,
	input  logic [fetch_pkg::addr_width-1:0] advance_pc2,
	input  logic                             fire1,
	input  logic                             fire2,
	input  logic [fetch_pkg::word_width-1:0] imem2proc_data,
	output logic [fetch_pkg::addr_width-1:0] proc2imem_addr,
	output logic [fetch_pkg::inst_width-1:0] inst1_out,
	output logic [fetch_pkg::inst_width-1:0] inst2_out,
	output logic                             inst1_valid,
	output logic                             inst2_valid,
	output logic                             inst_thread,
	output logic [fetch_pkg::addr_width-1:0] next_pc_out
);

	import fetch_pkg::*;

	logic [addr_width-1:0] owner_pc;
	logic [addr_width-1:0] fire_pc;
	logic [addr_width-1:0] fire_advance;
	logic                  any_fire;
	logic [inst_width-1:0] lower_inst;
	logic [inst_width-1:0] upper_inst;
	logic [inst_width-1:0] slot1_inst;
	logic [inst_width-1:0] slot2_inst;
	logic                  slot2_used;

	//////////////////////////////////////////////////
	// memory address
	//////////////////////////////////////////////////

	// program_start shows thread 1's address, nobody fetches then anyway
	assign owner_pc       = (owner_state == thread2_is_ex) ? pc2 : pc1;
	assign proc2imem_addr = {owner_pc[addr_width-1:3], 3'b000};   // word aligned

	//////////////////////////////////////////////////
	// instruction split
	//////////////////////////////////////////////////

	assign any_fire     = fire1 | fire2;
	assign fire_pc      = fire2 ? pc2 : pc1;
	assign fire_advance = fire2 ? advance_pc2 : advance_pc1;

	assign lower_inst = imem2proc_data[inst_width-1:0];            // at the aligned address
	assign upper_inst = imem2proc_data[word_width-1:inst_width];   // at aligned + 4

	always_comb
	begin
		if (fire_pc[2])
		begin
			slot1_inst = upper_inst;   // entered mid-word, only the upper half is ours
			slot2_inst = '0;
			slot2_used = 1'b0;
		end
		else
		begin
			slot1_inst = lower_inst;
			slot2_inst = upper_inst;
			slot2_used = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			inst1_valid <= 1'b0;
			inst2_valid <= 1'b0;
		end
		else
		begin
			inst1_valid <= any_fire;
			inst2_valid <= any_fire & slot2_used;
		end
	end

	// payload goes to zero when nothing was fetched
	always_ff @(posedge clock)
	begin
		inst1_out   <= any_fire ? slot1_inst : '0;
		inst2_out   <= (any_fire && slot2_used) ? slot2_inst : '0;
		inst_thread <= fire2;   // 0 for thread 1, 1 for thread 2
		next_pc_out <= any_fire ? fire_advance : '0;
	end

endmodule

//--- design/thread_pc.sv
// a redirect wins over a fetch in the same cycle; stalls hold the pc but do not block a redirect
`timescale 1ns/1ps

module thread_pc
(
	input  logic                            clock,
	input  logic                            reset,
	input  logic [fetch_pkg::addr_width-1:0] reset_pc,
	input  logic                            pc_enable,
	input  logic                            imem2proc_valid,
	input  logic                            rs_stall,
	input  logic                            rat_stall,
	input  logic                            rob_stall,
	input  logic                            structure_hazard_stall,
	input  logic                            branch_taken,
	input  logic [fetch_pkg::addr_width-1:0] target_pc,
	output logic [fetch_pkg::addr_width-1:0] pc,
	output logic [fetch_pkg::addr_width-1:0] advance_pc,
	output logic                            fire
);

	import fetch_pkg::*;

	logic any_stall;
	logic upper_half;   // pc points at the second instruction of a word

	//////////////////////////////////////////////////
	// fetch acceptance
	//////////////////////////////////////////////////

	// any back-end structure that is full holds this thread
	assign any_stall = rs_stall | rat_stall | rob_stall | structure_hazard_stall;

	assign fire = pc_enable & imem2proc_valid & ~any_stall & ~branch_taken;

	//////////////////////////////////////////////////
	// sequential next pc
	//////////////////////////////////////////////////

	assign upper_half = pc[2];

	always_comb
	begin
		if (upper_half)
		begin
			advance_pc = pc + addr_width'(4);   // one instruction left in this word
		end
		else
		begin
			advance_pc = pc + addr_width'(8);   // both halves consumed
		end
	end

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= reset_pc;
		end
		else if (branch_taken)
		begin
			pc <= target_pc;   // redirect from the branch unit
		end
		else if (fire)
		begin
			pc <= advance_pc;
		end
	end

endmodule

//--- design/slice_timer.sv
// keeps counting in single-thread mode and reloads itself after each slice_done
`timescale 1ns/1ps

module slice_timer
(
	input  logic clock,
	input  logic reset,
	input  logic restart,
	output logic slice_done
);

	import fetch_pkg::*;

	logic [slice_count_width-1:0] count;   // cycles left in the slice, minus one

	// last cycle of the slice
	assign slice_done = (count == '0);

	always_ff @(posedge clock)
	begin
		if (reset || restart || slice_done)
		begin
			count <= slice_count_width'(slice_cycles - 1);
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

endmodule

//--- design/thread_select_fsm.sv
// single-thread mode always hands the port to thread 1; slice_done is ignored there
`timescale 1ns/1ps

module thread_select_fsm
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   is_two_threads,
	input  logic                   slice_done,
	output fetch_pkg::thread_state owner_state,
	output logic                   pc_enable1,
	output logic                   pc_enable2,
	output logic                   slice_restart,
	output logic                   thread1_active
);

	import fetch_pkg::*;

	thread_state state;
	thread_state next_state;

	//////////////////////////////////////////////////
	// state register
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= program_start;
		end
		else
		begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			program_start:
			begin
				next_state = thread1_is_ex;   // thread 1 always goes first
			end
			thread1_is_ex:
			begin
				if (is_two_threads && slice_done)
					next_state = thread2_is_ex;
			end
			thread2_is_ex:
			begin
				// dropping to one thread pulls the port back at once
				if (!is_two_threads || slice_done)
					next_state = thread1_is_ex;
			end
			default:
			begin
				next_state = program_start;
			end
		endcase
	end

	// new slice starts whenever ownership moves
	assign slice_restart = (next_state != state);

	//////////////////////////////////////////////////
	// decoded outputs
	//////////////////////////////////////////////////

	assign owner_state    = state;
	assign pc_enable1     = (state == thread1_is_ex);
	assign pc_enable2     = (state == thread2_is_ex);
	assign thread1_active = (state == thread1_is_ex);   // same as enable 1, kept for the core

endmodule

//--- design/fetch_pkg.sv
// assumes a 64-bit byte address space and 64-bit memory words that each hold two instructions
package fetch_pkg;

	//////////////////////////////////////////////////
	// datapath widths
	//////////////////////////////////////////////////

	localparam int addr_width = 64;                  // pc and memory address
	localparam int inst_width = 32;                  // one instruction
	localparam int word_width = 2 * inst_width;      // one memory word, two instructions

	//////////////////////////////////////////////////
	// time slicing
	//////////////////////////////////////////////////

	// cycles a thread keeps the fetch port in two-thread mode
	localparam int slice_cycles = 4;

	// a single-cycle slice still needs one counter bit
	localparam int slice_count_width = (slice_cycles > 1) ? $clog2(slice_cycles) : 1;

	//////////////////////////////////////////////////
	// start addresses
	//////////////////////////////////////////////////

	localparam logic [addr_width-1:0] thread1_reset_pc = addr_width'('h0);
	localparam logic [addr_width-1:0] thread2_reset_pc = addr_width'('h1000);

	//////////////////////////////////////////////////
	// ownership of the fetch port
	//////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		program_start,   // one idle cycle out of reset
		thread1_is_ex,   // thread 1 fetches
		thread2_is_ex    // thread 2 fetches
	} thread_state;

endpackage
